/* hw/spi_flash_pkg.sv */
// Shared widths, counts, beat/config/control structs and the sequencer state enum
`default_nettype none

package spi_flash_pkg;

    // **************************************************
    // Widths and counts
    // **************************************************

    // Bits per serial byte, sent and received MSB first
    localparam int byte_bits = 8;
    // Active-low select lines on the board
    localparam int ncs_count = 3;
    // Chip select number, wider than needed so out-of-range picks are possible
    localparam int cs_width = 4;
    // Up to 31 dummy clocks between write and read phases
    localparam int dummy_width = 5;
    // Up to 15 read bytes per frame
    localparam int read_len_width = 4;
    // Bit position inside a byte
    localparam int bit_cnt_width = $clog2(byte_bits);

    // **************************************************
    // Types
    // **************************************************

    // One command beat, first beat of a packet carries the opcode
    typedef struct packed {
        logic                 sop;
        logic                 eop;
        logic [byte_bits-1:0] data;
    } cmd_beat_t;

    // Frame settings, captured with the sop beat
    typedef struct packed {
        logic [cs_width-1:0]       chip_select;
        logic [dummy_width-1:0]    dummy_cycles;
        logic [read_len_width-1:0] read_len;
    } frame_cfg_t;

    // Frame FSM states
    typedef enum logic [2:0] {
        idle,
        send_byte,
        wait_byte,
        dummy,
        read_byte,
        finish
    } seq_phase_e;

    // Per-cycle strobes from the sequencer to both shifters
    typedef struct packed {
        logic load;
        logic tx_shift;
        logic rx_shift;
        logic rx_done;
    } shift_ctrl_t;

endpackage

`default_nettype wire

/* hw/cmd_sequencer.sv */
// Frame FSM with bit, dummy and read-byte counters and frame setting capture
`default_nettype none

module cmd_sequencer (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire spi_flash_pkg::cmd_beat_t  in_cmd,
    input  wire logic                      in_cmd_valid,
    output logic                           in_cmd_ready,
    input  wire spi_flash_pkg::frame_cfg_t cfg_in,
    output spi_flash_pkg::frame_cfg_t      cfg,
    output spi_flash_pkg::shift_ctrl_t     shift_ctrl,
    output logic                           busy,
    output logic                           sclk_en
);

    import spi_flash_pkg::*;

    seq_phase_e                phase;
    seq_phase_e                phase_next;
    seq_phase_e                read_phase;
    seq_phase_e                tail_phase;
    frame_cfg_t                cfg_q;
    logic                      last_byte;
    logic                      start;
    logic                      bit_last;
    logic [bit_cnt_width-1:0]  bit_cnt;
    logic [dummy_width-1:0]    dummy_cnt;
    logic [read_len_width-1:0] read_cnt;

    // Last bit of the current byte is on the pins
    assign bit_last = (bit_cnt == bit_cnt_width'(byte_bits - 1));

    // Where the frame goes once the last written byte is out
    assign read_phase = (cfg_q.read_len != '0) ? read_byte : finish;
    assign tail_phase = (cfg_q.dummy_cycles != '0) ? dummy : read_phase;

    // Opcode beat taken in idle starts the frame
    assign start = (phase == idle) && shift_ctrl.load;

    // **************************************************
    // Frame FSM
    // **************************************************
    always_comb begin
        phase_next   = phase;
        in_cmd_ready = 1'b0;
        sclk_en      = 1'b0;
        shift_ctrl   = '0;
        case (phase)
            idle: begin
                in_cmd_ready = 1'b1;
                // Stray beats without sop are taken and dropped
                if (in_cmd_valid && in_cmd.sop) begin
                    shift_ctrl.load = 1'b1;
                    phase_next      = send_byte;
                end
            end
            send_byte: begin
                sclk_en             = 1'b1;
                shift_ctrl.tx_shift = 1'b1;
                if (bit_last) begin
                    if (last_byte) begin
                        phase_next = tail_phase;
                    end else if (in_cmd_valid) begin
                        // Next byte already waiting, load it with no gap
                        in_cmd_ready    = 1'b1;
                        shift_ctrl.load = 1'b1;
                    end else begin
                        phase_next = wait_byte;
                    end
                end
            end
            wait_byte: begin
                // Serial clock parked until the next beat shows up
                in_cmd_ready = 1'b1;
                if (in_cmd_valid) begin
                    shift_ctrl.load = 1'b1;
                    phase_next      = send_byte;
                end
            end
            dummy: begin
                sclk_en = 1'b1;
                if (dummy_cnt == '0) begin
                    phase_next = read_phase;
                end
            end
            read_byte: begin
                sclk_en             = 1'b1;
                shift_ctrl.rx_shift = 1'b1;
                if (bit_last) begin
                    shift_ctrl.rx_done = 1'b1;
                    if (read_cnt == '0) begin
                        phase_next = finish;
                    end
                end
            end
            finish: begin
                // Single cycle for ncs to go back high
                phase_next = idle;
            end
            default: begin
                phase_next = idle;
            end
        endcase
    end

    // **************************************************
    // State, settings and counters
    // **************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= idle;
            cfg_q     <= '0;
            last_byte <= 1'b0;
            bit_cnt   <= '0;
            dummy_cnt <= '0;
            read_cnt  <= '0;
        end else begin
            phase <= phase_next;
            if (start) begin
                cfg_q <= cfg_in;
            end
            // eop of each loaded beat marks the final written byte
            if (shift_ctrl.load) begin
                last_byte <= in_cmd.eop;
            end
            // Wraps to zero after each byte, so read bytes start aligned
            if (phase == send_byte || phase == read_byte) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else if (phase == idle) begin
                bit_cnt <= '0;
            end
            // Preloaded with count minus one outside the dummy phase
            if (phase == dummy) begin
                dummy_cnt <= dummy_cnt - 1'b1;
            end else begin
                dummy_cnt <= cfg_q.dummy_cycles - 1'b1;
            end
            // Bytes still to read after the current one
            if (phase == read_byte) begin
                if (bit_last) begin
                    read_cnt <= read_cnt - 1'b1;
                end
            end else begin
                read_cnt <= cfg_q.read_len - 1'b1;
            end
        end
    end

    // Decoder sees the new settings already on the start cycle
    assign cfg  = start ? cfg_in : cfg_q;
    // High through the frame, low again from finish
    assign busy = (phase_next != idle);

    // Serial clock is never enabled outside a frame
    a_no_sclk_in_idle: assert property (@(posedge clk) disable iff (reset)
        phase == idle |-> !sclk_en);

    // Waiting for a beat never moves a bit at the same time
    a_wait_no_overlap: assert property (@(posedge clk) disable iff (reset)
        phase == wait_byte |-> !(in_cmd_ready && sclk_en));

endmodule

`default_nettype wire

/* hw/tx_shifter.sv */
// Command byte load and MSB-first serializer driving the serial output
`default_nettype none

module tx_shifter (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic [spi_flash_pkg::byte_bits-1:0] data,
    input  wire spi_flash_pkg::shift_ctrl_t          shift_ctrl,
    output logic                                     dout
);

    import spi_flash_pkg::*;

    // Byte being written, top bit is on the pin
    logic [byte_bits-1:0] shift_q;

    // **************************************************
    // Serializer
    // **************************************************

    // Load wins over shift on the last bit of a byte,
    // so back-to-back bytes leave no hole on dout
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            shift_q <= '0;
        end else if (shift_ctrl.load) begin
            shift_q <= data;
        end else if (shift_ctrl.tx_shift) begin
            // Zero fill, the pin idles low once the byte is out
            shift_q <= {shift_q[byte_bits-2:0], 1'b0};
        end
    end

    // MSB first
    assign dout = shift_q[byte_bits-1];

endmodule

`default_nettype wire

/* hw/rx_shifter.sv */
// Serial input sampler, read byte assembler and response pulse register
`default_nettype none

module rx_shifter (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        din,
    input  wire spi_flash_pkg::shift_ctrl_t  shift_ctrl,
    output logic [spi_flash_pkg::byte_bits-1:0] rsp_data,
    output logic                             rsp_valid
);

    import spi_flash_pkg::*;

    // Bits collected so far, oldest in the top position
    logic [byte_bits-1:0] shift_q;
    // Byte as it stands with the bit on din right now
    logic [byte_bits-1:0] assembled;

    assign assembled = {shift_q[byte_bits-2:0], din};

    // **************************************************
    // Byte assembly
    // **************************************************

    // din sampled on the edge that ends each read clock
    always_ff @(posedge clk) begin
        if (shift_ctrl.rx_shift) begin
            shift_q <= assembled;
        end
    end

    // Eighth bit goes straight into the response register
    always_ff @(posedge clk) begin
        if (shift_ctrl.rx_done) begin
            rsp_data <= assembled;
        end
    end

    // **************************************************
    // Response pulse
    // **************************************************

    // One cycle per byte, no back-pressure from the consumer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= shift_ctrl.rx_done;
        end
    end

endmodule

`default_nettype wire

/* hw/chip_select_decoder.sv */
// Registered chip select decoder to active-low select lines
`default_nettype none

module chip_select_decoder (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire spi_flash_pkg::frame_cfg_t           cfg,
    input  wire logic                                busy,
    output logic [spi_flash_pkg::ncs_count-1:0]      ncs
);

    import spi_flash_pkg::*;

    // Active-high line picked for this frame
    logic [ncs_count-1:0] select;

    // **************************************************
    // Decode
    // **************************************************

    // Numbers at or above ncs_count match no line at all,
    // the frame still runs with every device deselected
    always_comb begin
        select = '0;
        for (int i = 0; i < ncs_count; i++) begin
            if (busy && cfg.chip_select == cs_width'(i)) begin
                select[i] = 1'b1;
            end
        end
    end

    // One cycle behind busy, all lines high out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ncs <= '1;
        end else begin
            ncs <= ~select;
        end
    end

    // Never more than one device on the bus
    a_one_device: assert property (@(posedge clk) disable iff (reset)
        $onehot0(~ncs));

endmodule

`default_nettype wire

/* hw/spi_flash_ctrl.sv */
// Top level of the serial flash command engine, sequencer, shifters and decoder
`default_nettype none

module spi_flash_ctrl (
    input  wire logic                                     clk,
    input  wire logic                                     reset,
    // Command packet, one byte per beat
    input  wire spi_flash_pkg::cmd_beat_t                 in_cmd,
    input  wire logic                                     in_cmd_valid,
    output logic                                          in_cmd_ready,
    // Frame settings, sampled with the sop beat
    input  wire logic [spi_flash_pkg::cs_width-1:0]       chip_select,
    input  wire logic [spi_flash_pkg::dummy_width-1:0]    dummy_cycles,
    input  wire logic [spi_flash_pkg::read_len_width-1:0] read_len,
    // Read bytes
    output logic [spi_flash_pkg::byte_bits-1:0]           rsp_data,
    output logic                                          rsp_valid,
    // Serial flash pins
    output logic [spi_flash_pkg::ncs_count-1:0]           ncs,
    output logic                                          sclk_en,
    output logic                                          dout,
    input  wire logic                                     din
);

    import spi_flash_pkg::*;

    frame_cfg_t  cfg_in;
    frame_cfg_t  cfg;
    shift_ctrl_t shift_ctrl;
    logic        busy;

    // Config ports bundled for capture
    assign cfg_in = '{chip_select: chip_select, dummy_cycles: dummy_cycles, read_len: read_len};

    // **************************************************
    // Control
    // **************************************************
    cmd_sequencer cmd_sequencer_i (
        .clk          (clk),
        .reset        (reset),
        .in_cmd       (in_cmd),
        .in_cmd_valid (in_cmd_valid),
        .in_cmd_ready (in_cmd_ready),
        .cfg_in       (cfg_in),
        .cfg          (cfg),
        .shift_ctrl   (shift_ctrl),
        .busy         (busy),
        .sclk_en      (sclk_en)
    );

    // **************************************************
    // Datapath
    // **************************************************

    // Write side takes the beat byte directly
    tx_shifter tx_shifter_i (
        .clk        (clk),
        .reset      (reset),
        .data       (in_cmd.data),
        .shift_ctrl (shift_ctrl),
        .dout       (dout)
    );

    rx_shifter rx_shifter_i (
        .clk        (clk),
        .reset      (reset),
        .din        (din),
        .shift_ctrl (shift_ctrl),
        .rsp_data   (rsp_data),
        .rsp_valid  (rsp_valid)
    );

    chip_select_decoder chip_select_decoder_i (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg),
        .busy  (busy),
        .ncs   (ncs)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// Testbench clock and power-on reset generator
`default_nettype none

module tb_clock #(
    parameter int period       = 10,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic reset
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset released just after a rising edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/flash_checker.sv */
// Frame checker comparing serial pins, select lines and responses with the expected frame
`default_nettype none

module flash_checker #(
    parameter int max_pkt  = 6,
    parameter int max_read = 4
) (
    input  wire logic                                          clk,
    input  wire logic                                          reset,
    // DUT pins
    input  wire logic                                          in_cmd_ready,
    input  wire logic                                          sclk_en,
    input  wire logic                                          dout,
    input  wire logic [spi_flash_pkg::byte_bits-1:0]           rsp_data,
    input  wire logic                                          rsp_valid,
    input  wire logic [spi_flash_pkg::ncs_count-1:0]           ncs,
    // Expected frame from the stimulus
    input  wire logic                                          frame_start,
    input  wire logic                                          frame_end,
    input  wire logic [15:0]                                   test_id,
    input  wire logic [7:0]                                    exp_len,
    input  wire logic [spi_flash_pkg::dummy_width-1:0]         exp_dummy,
    input  wire logic [spi_flash_pkg::read_len_width-1:0]      exp_read_len,
    input  wire logic [spi_flash_pkg::cs_width-1:0]            exp_cs,
    input  wire logic [max_pkt*spi_flash_pkg::byte_bits-1:0]  exp_bytes,
    input  wire logic [max_read*spi_flash_pkg::byte_bits-1:0] exp_rsp,
    output int                                                 error_count,
    output int                                                 check_count
);

    import spi_flash_pkg::*;

    // Frame latched at its start, so the stimulus may move on early
    int                            test_q;
    int                            len_q;
    int                            dummy_q;
    int                            read_q;
    int                            cs_q;
    logic [max_pkt*byte_bits-1:0]  bytes_q;
    logic [max_read*byte_bits-1:0] rsp_q;
    // Progress inside the current frame
    int                            sclk_cnt;
    int                            rsp_cnt;
    logic [byte_bits-1:0]          bits_q;
    logic                          saw_low;
    logic                          active;
    logic                          reset_checked;

    function automatic string test_name();
        return $sformatf("frame_%0d", test_q);
    endfunction

    // Line that should go low, zero for an out-of-range select
    function automatic logic [ncs_count-1:0] select_mask();
        if (cs_q < ncs_count) begin
            return ncs_count'(1) << cs_q;
        end
        return '0;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("FAILED %s %s: expected 0x%0h, actual 0x%0h",
                     test_name(), what, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("%s: %s", test_name(), what);
    endtask

    // **************************************************
    // Frame bookkeeping
    // **************************************************
    task automatic open_frame();
        test_q   = int'(test_id);
        len_q    = int'(exp_len);
        dummy_q  = int'(exp_dummy);
        read_q   = int'(exp_read_len);
        cs_q     = int'(exp_cs);
        bytes_q  = exp_bytes;
        rsp_q    = exp_rsp;
        sclk_cnt = 0;
        rsp_cnt  = 0;
        bits_q   = '0;
        saw_low  = 1'b0;
        active   = 1'b1;
    endtask

    task automatic close_frame();
        // Gaps in valid only stretch the frame, the clock count is fixed
        check_value("serial clock count",
                    byte_bits * len_q + dummy_q + byte_bits * read_q, sclk_cnt);
        check_value("response count", read_q, rsp_cnt);
        if (select_mask() != '0 && !saw_low) begin
            report_error("the selected ncs line never went low");
        end
        active = 1'b0;
    endtask

    // **************************************************
    // Per-cycle watch
    // **************************************************
    task automatic watch_cycle();
        logic [ncs_count-1:0] sel;
        sel = select_mask();
        if (!active) begin
            if (ncs != '1 || sclk_en || rsp_valid) begin
                report_error("serial pins or responses active between frames");
            end
            return;
        end
        // Select 3 means every line stays high
        if (ncs != '1) begin
            saw_low = 1'b1;
            if (ncs != ~sel) begin
                report_error("wrong ncs lines low for the chip select");
            end
        end
        if (sclk_en && sel != '0 && (ncs & sel) != '0) begin
            report_error("selected ncs line high while the serial clock runs");
        end
        // Written bytes, MSB first, opcode first
        if (sclk_en) begin
            if (sclk_cnt < byte_bits * len_q) begin
                bits_q = {bits_q[byte_bits-2:0], dout};
                if (sclk_cnt % byte_bits == byte_bits - 1) begin
                    check_value($sformatf("write byte %0d", sclk_cnt / byte_bits),
                                int'(byte_bits'(bytes_q >> (byte_bits * (sclk_cnt / byte_bits)))),
                                int'(bits_q));
                end
            end
            sclk_cnt++;
        end
        if (rsp_valid) begin
            if (rsp_cnt < read_q) begin
                check_value($sformatf("read byte %0d", rsp_cnt),
                            int'(byte_bits'(rsp_q >> (byte_bits * rsp_cnt))), int'(rsp_data));
            end else begin
                report_error("more response pulses than the read length");
            end
            rsp_cnt++;
        end
    endtask

    // Mid-cycle sampling, all inputs settled since just after the rising edge
    always @(negedge clk) begin
        if (reset) begin
            error_count   = 0;
            check_count   = 0;
            active        = 1'b0;
            reset_checked = 1'b0;
            test_q        = 0;
        end else begin
            if (!reset_checked) begin
                check_count++;
                if (ncs != '1 || sclk_en || rsp_valid || !in_cmd_ready) begin
                    error_count++;
                    $display("DUT not idle after reset: ncs=%b sclk_en=%b rsp_valid=%b ready=%b",
                             ncs, sclk_en, rsp_valid, in_cmd_ready);
                end
                reset_checked = 1'b1;
            end
            if (frame_end) begin
                close_frame();
            end
            if (frame_start) begin
                open_frame();
            end
            watch_cycle();
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_spi_flash_ctrl.sv */
// Testbench top with DUT, flash model, packet stimulus, reference function and watchdog
`default_nettype none

module tb_spi_flash_ctrl;

    import spi_flash_pkg::*;

    localparam int          num_tests  = 40;
    localparam int          max_pkt    = 6;
    localparam int          max_read   = 4;
    localparam int          max_dummy  = 10;
    // Gaps longer than one byte on the pins park the FSM in wait_byte
    localparam int          max_gap    = 12;
    localparam logic [31:0] seed       = 32'd61;
    localparam int          clk_period = 10;
    localparam int          pkt_bits   = max_pkt * byte_bits;
    localparam int          rsp_bits   = max_read * byte_bits;
    // Longest frame in bytes, dummy clocks counted as two more
    localparam int          longest    = max_pkt + max_read + 2;
    localparam int          timeout    = num_tests * longest * 40 * clk_period;

    logic                      clk;
    logic                      reset;
    cmd_beat_t                 in_cmd;
    logic                      in_cmd_valid;
    logic                      in_cmd_ready;
    logic [cs_width-1:0]       chip_select;
    logic [dummy_width-1:0]    dummy_cycles;
    logic [read_len_width-1:0] read_len;
    logic [byte_bits-1:0]      rsp_data;
    logic                      rsp_valid;
    logic [ncs_count-1:0]      ncs;
    logic                      sclk_en;
    logic                      dout;
    logic                      din;

    // Expected frame handed to the checker
    logic                      frame_start;
    logic                      frame_end;
    logic [15:0]               test_id;
    logic [7:0]                exp_len;
    logic [dummy_width-1:0]    exp_dummy;
    logic [read_len_width-1:0] exp_read_len;
    logic [cs_width-1:0]       exp_cs;
    logic [pkt_bits-1:0]       exp_bytes;
    logic [rsp_bits-1:0]       exp_rsp;
    int                        error_count;
    int                        check_count;

    // Flash model state
    logic [byte_bits-1:0]      cur_opcode;
    int                        cur_len;
    int                        cur_dummy;
    int                        model_cnt;
    logic [31:0]               rng_state;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Draw in 0 .. range-1
    function automatic int next_rand(input int range);
        rng_state = xorshift(rng_state);
        return int'(rng_state % 32'(range));
    endfunction

    // Byte the model flash returns at read position index after opcode
    function automatic logic [byte_bits-1:0] flash_byte(input logic [byte_bits-1:0] opcode,
                                                        input int index);
        logic [byte_bits-1:0] rot;
        int                   sh;
        sh  = index % byte_bits;
        rot = (opcode << sh) | (opcode >> (byte_bits - sh));
        return rot ^ byte_bits'(index * 37);
    endfunction

    // din for serial clock k of the frame, zero outside the read region
    function automatic logic model_bit(input int k, input logic [byte_bits-1:0] opcode,
                                       input int len, input int dum);
        int                   off;
        logic [byte_bits-1:0] b;
        off = k - byte_bits * len - dum;
        if (off < 0) begin
            return 1'b0;
        end
        b = flash_byte(opcode, off / byte_bits);
        return 1'(b >> (byte_bits - 1 - off % byte_bits));
    endfunction

    tb_clock #(.period(clk_period), .reset_cycles(2)) tb_clock_i (
        .clk   (clk),
        .reset (reset)
    );

    spi_flash_ctrl spi_flash_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .in_cmd       (in_cmd),
        .in_cmd_valid (in_cmd_valid),
        .in_cmd_ready (in_cmd_ready),
        .chip_select  (chip_select),
        .dummy_cycles (dummy_cycles),
        .read_len     (read_len),
        .rsp_data     (rsp_data),
        .rsp_valid    (rsp_valid),
        .ncs          (ncs),
        .sclk_en      (sclk_en),
        .dout         (dout),
        .din          (din)
    );

    flash_checker #(.max_pkt(max_pkt), .max_read(max_read)) flash_checker_i (
        .clk          (clk),
        .reset        (reset),
        .in_cmd_ready (in_cmd_ready),
        .sclk_en      (sclk_en),
        .dout         (dout),
        .rsp_data     (rsp_data),
        .rsp_valid    (rsp_valid),
        .ncs          (ncs),
        .frame_start  (frame_start),
        .frame_end    (frame_end),
        .test_id      (test_id),
        .exp_len      (exp_len),
        .exp_dummy    (exp_dummy),
        .exp_read_len (exp_read_len),
        .exp_cs       (exp_cs),
        .exp_bytes    (exp_bytes),
        .exp_rsp      (exp_rsp),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    // **************************************************
    // Flash model
    // **************************************************

    // Clock count restarts with each accepted sop beat, so an
    // out-of-range select still gets read data
    initial begin
        din       = 1'b0;
        model_cnt = 0;
        forever begin
            @(negedge clk);
            if (in_cmd_valid && in_cmd_ready && in_cmd.sop) begin
                model_cnt = 0;
            end else if (sclk_en) begin
                model_cnt = model_cnt + 1;
            end
            @(posedge clk);
            #1;
            din = model_bit(model_cnt, cur_opcode, cur_len, cur_dummy);
        end
    end

    // **************************************************
    // Stimulus
    // **************************************************

    // Holds one beat until ready is seen, clears the checker strobes after one cycle
    task automatic send_beat(input logic sop, input logic eop, input logic [byte_bits-1:0] data);
        logic taken;
        in_cmd.sop   = sop;
        in_cmd.eop   = eop;
        in_cmd.data  = data;
        in_cmd_valid = 1'b1;
        taken        = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_cmd_ready;
            @(posedge clk);
            #1;
            frame_start = 1'b0;
            frame_end   = 1'b0;
        end
        in_cmd_valid = 1'b0;
    endtask

    task automatic run_frame(input int t);
        int   len;
        int   dum;
        int   rlen;
        int   cs;
        logic gaps;
        logic idle_seen;
        len  = 1 + next_rand(max_pkt);
        dum  = next_rand(max_dummy + 1);
        rlen = next_rand(max_read + 1);
        cs   = next_rand(ncs_count + 1);
        gaps = (next_rand(3) == 0);
        exp_bytes = '0;
        for (int i = 0; i < len; i++) begin
            exp_bytes = exp_bytes | (pkt_bits'(next_rand(256)) << (byte_bits * i));
        end
        // Expected read bytes from the reference function
        exp_rsp = '0;
        for (int i = 0; i < max_read; i++) begin
            exp_rsp = exp_rsp | (rsp_bits'(flash_byte(byte_bits'(exp_bytes), i)) << (byte_bits * i));
        end
        cur_opcode   = byte_bits'(exp_bytes);
        cur_len      = len;
        cur_dummy    = dum;
        test_id      = 16'(t);
        exp_len      = 8'(len);
        exp_dummy    = dummy_width'(dum);
        exp_read_len = read_len_width'(rlen);
        exp_cs       = cs_width'(cs);
        // Previous frame closes in the same cycle this one opens
        frame_end    = (t != 0);
        frame_start  = 1'b1;
        chip_select  = cs_width'(cs);
        dummy_cycles = dummy_width'(dum);
        read_len     = read_len_width'(rlen);
        for (int i = 0; i < len; i++) begin
            if (gaps && i != 0) begin
                repeat (next_rand(max_gap)) begin
                    @(posedge clk);
                    #1;
                end
            end
            send_beat(i == 0, i == len - 1, byte_bits'(exp_bytes >> (byte_bits * i)));
        end
        // After eop, ready comes back only in idle
        idle_seen = 1'b0;
        while (!idle_seen) begin
            @(negedge clk);
            idle_seen = in_cmd_ready;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        rng_state    = seed;
        in_cmd       = '0;
        in_cmd_valid = 1'b0;
        chip_select  = '0;
        dummy_cycles = '0;
        read_len     = '0;
        frame_start  = 1'b0;
        frame_end    = 1'b0;
        test_id      = '0;
        exp_len      = '0;
        exp_dummy    = '0;
        exp_read_len = '0;
        exp_cs       = '0;
        exp_bytes    = '0;
        exp_rsp      = '0;
        cur_opcode   = '0;
        cur_len      = 0;
        cur_dummy    = 0;
        @(negedge reset);
        @(posedge clk);
        #1;
        for (int t = 0; t < num_tests; t++) begin
            run_frame(t);
        end
        // Close the last frame
        frame_end = 1'b1;
        @(posedge clk);
        #1;
        frame_end = 1'b0;
        @(posedge clk);
        $display("Frames: %0d, checks: %0d, errors: %0d", num_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the longest frame
    initial begin
        #(timeout);
        $display("Timeout: frames did not complete within %0d time units", timeout);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* spi_flash_ctrl.f */
hw/spi_flash_pkg.sv
hw/cmd_sequencer.sv
hw/tx_shifter.sv
hw/rx_shifter.sv
hw/chip_select_decoder.sv
hw/spi_flash_ctrl.sv
testbench/tb_clock.sv
testbench/flash_checker.sv
testbench/tb_spi_flash_ctrl.sv

/* Makefile */
TOP := tb_spi_flash_ctrl

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module $(TOP) -f spi_flash_ctrl.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
